// File: filelist.f
src/csr_pkg.sv
src/csr_decode.sv
src/csr_execute.sv
src/csr_counters.sv
src/csr_readout.sv
src/csr_unit.sv
dv/csr_unit_assertions.sv
dv/csr_unit_tb.sv

// File: Makefile
# Verilator build and run of the CSR unit testbench

all: run

obj_dir/Vcsr_unit_tb: filelist.f $(wildcard src/*.sv dv/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module csr_unit_tb -f filelist.f

run: obj_dir/Vcsr_unit_tb
	obj_dir/Vcsr_unit_tb > sim.log 2>&1; cat sim.log
	@! grep -q "Simulation finished: FAIL" sim.log
	@grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

// File: dv/csr_unit_tb.sv
// Testbench for the CSR unit with clock, reset, random CSR traffic, reference model and checks
`timescale 1ns/1ps

module csr_unit_tb;

    localparam logic [31:0] HART_ID = 32'h0000_0005;
    localparam int RMW_OPS = 80;
    localparam int ILLEGAL_OPS = 80;
    localparam int TRAP_ROUNDS = 30;
    localparam int COUNTER_ROUNDS = 10;
    // At most 4 cycles per access with gaps included
    localparam int TIMEOUT = (13 + RMW_OPS + ILLEGAL_OPS + 5 * TRAP_ROUNDS
                              + 12 * COUNTER_ROUNDS) * 4 + 200;

    logic clk, rst, new_request, read_regs, commit, exception_valid, mret, illegal;
    logic [11:0] csr_addr;
    csr_pkg::csr_op_t csr_op;
    logic [31:0] rs1, exception_pc, exception_tval, wb_csr, trap_pc, csr_mepc;
    logic [4:0] exception_code;
    logic [1:0] retire_inc;

    // Reference model
    logic [31:0] m_mstatus = '0, m_mie = '0, m_mtvec = '0, m_mscratch = '0;
    logic [31:0] m_mepc = '0, m_mcause = '0, m_mtval = '0, m_mip = '0, expect_wb = '0;
    logic [63:0] m_cycle = '0, m_instret = '0;
    logic [31:0] seed = 32'h7915;
    int cycles = 0, capture_cycle = 0, checks = 0, errors = 0;
    bit trap_noise = 1'b0;

    // Writable registers before constants before counters
    logic [11:0] known [23] = '{
        csr_pkg::ADDR_MSTATUS, csr_pkg::ADDR_MIE, csr_pkg::ADDR_MTVEC, csr_pkg::ADDR_MSCRATCH,
        csr_pkg::ADDR_MEPC, csr_pkg::ADDR_MCAUSE, csr_pkg::ADDR_MTVAL, csr_pkg::ADDR_MIP,
        csr_pkg::ADDR_MISA, csr_pkg::ADDR_MVENDORID, csr_pkg::ADDR_MARCHID,
        csr_pkg::ADDR_MIMPID, csr_pkg::ADDR_MHARTID,
        csr_pkg::ADDR_MCYCLE, csr_pkg::ADDR_MCYCLEH, csr_pkg::ADDR_MINSTRET,
        csr_pkg::ADDR_MINSTRETH, csr_pkg::ADDR_CYCLE, csr_pkg::ADDR_CYCLEH, csr_pkg::ADDR_TIME,
        csr_pkg::ADDR_TIMEH, csr_pkg::ADDR_INSTRET, csr_pkg::ADDR_INSTRETH
    };

    csr_unit #(.hart_id(HART_ID)) UUT (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        repeat (TIMEOUT) @(posedge clk);
        $display("timeout: run did not complete within %0d cycles", TIMEOUT);
        $display("Simulation finished: FAIL");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // Model helpers
    function automatic logic [31:0] next_rand();
        seed ^= seed << 13;
        seed ^= seed >> 17;
        seed ^= seed << 5;
        return seed;
    endfunction

    function automatic bit known_addr(input logic [11:0] addr);
        foreach (known[i]) begin
            if (known[i] == addr)
                return 1'b1;
        end
        return 1'b0;
    endfunction

    function automatic logic [31:0] model_read(input logic [11:0] addr);
        case (addr)
            csr_pkg::ADDR_MSTATUS:  return m_mstatus | csr_pkg::MSTATUS_MPP_VAL;
            csr_pkg::ADDR_MIE:      return m_mie;
            csr_pkg::ADDR_MTVEC:    return m_mtvec;
            csr_pkg::ADDR_MSCRATCH: return m_mscratch;
            csr_pkg::ADDR_MEPC:     return m_mepc;
            csr_pkg::ADDR_MCAUSE:   return m_mcause;
            csr_pkg::ADDR_MTVAL:    return m_mtval;
            csr_pkg::ADDR_MIP:      return m_mip;
            csr_pkg::ADDR_MISA:     return csr_pkg::MISA_VAL;
            csr_pkg::ADDR_MHARTID:  return HART_ID;
            csr_pkg::ADDR_MCYCLE, csr_pkg::ADDR_CYCLE,
            csr_pkg::ADDR_TIME:     return m_cycle[31:0];
            csr_pkg::ADDR_MCYCLEH, csr_pkg::ADDR_CYCLEH,
            csr_pkg::ADDR_TIMEH:    return m_cycle[63:32];
            csr_pkg::ADDR_MINSTRET, csr_pkg::ADDR_INSTRET: return m_instret[31:0];
            csr_pkg::ADDR_MINSTRETH, csr_pkg::ADDR_INSTRETH: return m_instret[63:32];
            default:                return '0;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("error %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // One clock edge where the model follows the DUT before the next inputs
    task automatic tick();
        logic [31:0] v;
        logic [31:0] captured;
        bit write_en;
        @(posedge clk);
        cycles++;
        captured = read_regs ? model_read(csr_addr) : expect_wb;
        if (read_regs)
            capture_cycle = cycles;
        v = (csr_op == csr_pkg::RS) ? (expect_wb | rs1) :
            (csr_op == csr_pkg::RC) ? (expect_wb & ~rs1) : rs1;
        write_en = commit && csr_addr[11:10] != 2'b11;
        if (!rst) begin
            m_cycle++;
            m_instret += {62'b0, retire_inc};
            if (write_en) begin
                case (csr_addr)
                    csr_pkg::ADDR_MIE:      m_mie = v & csr_pkg::MIE_MIP_MASK;
                    csr_pkg::ADDR_MIP:      m_mip = v & csr_pkg::MIE_MIP_MASK;
                    csr_pkg::ADDR_MTVEC:    m_mtvec = v & ~32'h3;
                    csr_pkg::ADDR_MSCRATCH: m_mscratch = v;
                    csr_pkg::ADDR_MEPC:     m_mepc = v & ~32'h3;
                    csr_pkg::ADDR_MCAUSE:   m_mcause = v & 32'h8000_001F;
                    csr_pkg::ADDR_MTVAL:    m_mtval = v;
                    default: ;
                endcase
            end
            // Trap entry overrides the writes above and any mret
            if (exception_valid) begin
                m_mstatus[7] = m_mstatus[3];
                m_mstatus[3] = 1'b0;
                m_mepc = exception_pc & ~32'h3;
                m_mcause = {27'b0, exception_code};
                m_mtval = exception_tval;
            end else if (mret) begin
                m_mstatus[3] = m_mstatus[7];
                m_mstatus[7] = 1'b1;
            end
            if (write_en && csr_addr == csr_pkg::ADDR_MSTATUS)
                m_mstatus = v & csr_pkg::MSTATUS_WR_MASK;
        end
        expect_wb = captured;
        #1;
        new_request = 1'b0;
        read_regs = 1'b0;
        commit = 1'b0;
        exception_valid = 1'b0;
        mret = 1'b0;
        v = next_rand();
        retire_inc = v[1:0];
        if (trap_noise) begin
            exception_valid = (v[4:2] == 3'd0);
            mret = (v[7:5] == 3'd0);
            exception_code = v[12:8];
            exception_pc = next_rand();
            exception_tval = next_rand();
        end
    endtask

    // Cycle A reads and cycle B commits
    task automatic access(input logic [11:0] addr, input csr_pkg::csr_op_t op,
                          input logic [31:0] data, input bit write);
        csr_addr = addr;
        csr_op = op;
        rs1 = data;
        new_request = 1'b1;
        read_regs = 1'b1;
        #1;
        check_value("illegal", {31'b0, illegal}, {31'b0, !known_addr(addr)});
        tick();
        commit = write && known_addr(addr);
        #1;
        check_value("wb_csr", wb_csr, expect_wb);
        check_value("trap_pc", trap_pc, m_mtvec);
        check_value("csr_mepc", csr_mepc, m_mepc);
        tick();
    endtask

    ////////////////////////////////////////////////////////////
    // Tests
    initial begin
        int base;
        int first_cycle;
        logic [31:0] r;
        logic [31:0] first_value;
        logic [11:0] addr;
        rst = 1'b1;
        csr_addr = '0;
        csr_op = csr_pkg::RW;
        rs1 = '0;
        new_request = 1'b0;
        read_regs = 1'b0;
        commit = 1'b0;
        exception_valid = 1'b0;
        exception_code = '0;
        exception_pc = '0;
        exception_tval = '0;
        mret = 1'b0;
        retire_inc = '0;
        repeat (5) tick();
        rst = 1'b0;

        base = errors;
        // Writeback register and illegal flag leave reset cleared
        check_value("wb_csr", wb_csr, 32'h0);
        check_value("illegal", {31'b0, illegal}, 32'h0);
        for (int i = 0; i < 13; i++)
            access(known[i], csr_pkg::RS, 32'h0, 1'b0);
        $display("test reset_values: %0d errors", errors - base);

        base = errors;
        for (int i = 0; i < RMW_OPS; i++) begin
            r = next_rand();
            access(known[r[2:0]], csr_pkg::csr_op_t'(r[4:3] % 2'd3 + 2'd1), next_rand(), 1'b1);
        end
        $display("test read_modify_write: %0d errors", errors - base);

        // Random addresses with half of them drawn from the known table
        base = errors;
        for (int i = 0; i < ILLEGAL_OPS; i++) begin
            r = next_rand();
            addr = r[31] ? known[5'(r[16:12] % 5'd23)] : r[11:0];
            access(addr, csr_pkg::csr_op_t'(r[4:3] % 2'd3 + 2'd1), next_rand(), r[30]);
        end
        $display("test illegal_and_read_only: %0d errors", errors - base);

        base = errors;
        trap_noise = 1'b1;
        for (int i = 0; i < TRAP_ROUNDS; i++) begin
            r = next_rand();
            access(known[r[2:0]], csr_pkg::csr_op_t'(r[4:3] % 2'd3 + 2'd1), next_rand(), 1'b1);
            access(csr_pkg::ADDR_MSTATUS, csr_pkg::RS, 32'h0, 1'b0);
            access(csr_pkg::ADDR_MEPC, csr_pkg::RS, 32'h0, 1'b0);
            access(csr_pkg::ADDR_MCAUSE, csr_pkg::RS, 32'h0, 1'b0);
            access(csr_pkg::ADDR_MTVAL, csr_pkg::RS, 32'h0, 1'b0);
        end
        trap_noise = 1'b0;
        $display("test trap_entry_and_mret: %0d errors", errors - base);

        base = errors;
        for (int i = 0; i < COUNTER_ROUNDS; i++) begin
            access(csr_pkg::ADDR_MCYCLE, csr_pkg::RS, 32'h0, 1'b0);
            first_value = wb_csr;
            first_cycle = capture_cycle;
            repeat (next_rand() % 8) tick();
            for (int j = 13; j < 23; j++)
                access(known[j], csr_pkg::RS, 32'h0, 1'b0);
            access(csr_pkg::ADDR_MCYCLE, csr_pkg::RS, 32'h0, 1'b0);
            check_value("mcycle delta", wb_csr - first_value, 32'(capture_cycle - first_cycle));
        end
        $display("test counters: %0d errors", errors - base);

        $display("tests: 5, checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// File: dv/csr_unit_assertions.sv
// Bound assertions for the CSR unit ports on illegal, writeback hold and vector alignment
`timescale 1ns/1ps

module csr_unit_assertions (
    input logic        clk,
    input logic        rst,
    input logic        new_request,
    input logic        read_regs,
    input logic        illegal,
    input logic [31:0] wb_csr,
    input logic [31:0] trap_pc,
    input logic [31:0] csr_mepc
);

    illegal_needs_request: assert property (@(posedge clk) illegal |-> new_request)
        else $error("illegal raised without new_request");

    // Writeback only moves after a read strobe
    wb_csr_held: assert property (@(posedge clk) disable iff (rst)
        !$past(read_regs) |-> $stable(wb_csr))
        else $error("wb_csr changed without read_regs");

    trap_pc_aligned: assert property (@(posedge clk) disable iff (rst) trap_pc[1:0] == 2'b00)
        else $error("trap_pc not word aligned");

    mepc_aligned: assert property (@(posedge clk) disable iff (rst) csr_mepc[1:0] == 2'b00)
        else $error("csr_mepc not word aligned");

endmodule

bind csr_unit csr_unit_assertions u_assertions (
    .clk (clk), .rst (rst), .new_request (new_request), .read_regs (read_regs),
    .illegal (illegal), .wb_csr (wb_csr), .trap_pc (trap_pc), .csr_mepc (csr_mepc)
);

// File: src/csr_unit.sv
// CSR unit top level: decode, execute, counters and readout
`timescale 1ns/1ps

module csr_unit #(
    parameter logic [csr_pkg::XLEN-1:0] hart_id = '0
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [csr_pkg::CSR_ADDR_W-1:0]  csr_addr,
    input  csr_pkg::csr_op_t                csr_op,
    input  logic [csr_pkg::XLEN-1:0]        rs1,
    input  logic                            new_request,
    input  logic                            read_regs,
    input  logic                            commit,
    input  logic                            exception_valid,
    input  logic [csr_pkg::ECODE_W-1:0]     exception_code,
    input  logic [csr_pkg::XLEN-1:0]        exception_pc,
    input  logic [csr_pkg::XLEN-1:0]        exception_tval,
    input  logic                            mret,
    input  logic [csr_pkg::RETIRE_W-1:0]    retire_inc,
    output logic                            illegal,
    output logic [csr_pkg::XLEN-1:0]        wb_csr,
    output logic [csr_pkg::XLEN-1:0]        trap_pc,
    output logic [csr_pkg::XLEN-1:0]        csr_mepc
);

    csr_pkg::csr_sel_t              csr_sel;
    logic                           csr_write;
    logic [csr_pkg::XLEN-1:0]       mstatus;
    logic [csr_pkg::XLEN-1:0]       mie;
    logic [csr_pkg::XLEN-1:0]       mscratch;
    logic [csr_pkg::XLEN-1:0]       mcause;
    logic [csr_pkg::XLEN-1:0]       mtval;
    logic [csr_pkg::XLEN-1:0]       mip;
    logic [csr_pkg::COUNTER_W-1:0]  cycle_count;
    logic [csr_pkg::COUNTER_W-1:0]  instret_count;

    csr_decode u_decode (
        .csr_addr    (csr_addr),
        .new_request (new_request),
        .commit      (commit),
        .csr_sel     (csr_sel),
        .csr_write   (csr_write),
        .illegal     (illegal)
    );

    // mtvec and mepc leave the unit directly as trap_pc and csr_mepc
    csr_execute u_execute (
        .clk (clk), .rst (rst),
        .csr_sel (csr_sel), .csr_write (csr_write), .csr_op (csr_op),
        .rs1 (rs1), .old_value (wb_csr),
        .exception_valid (exception_valid), .exception_code (exception_code),
        .exception_pc (exception_pc), .exception_tval (exception_tval),
        .mret (mret),
        .mstatus (mstatus), .mie (mie), .mtvec (trap_pc), .mscratch (mscratch),
        .mepc (csr_mepc), .mcause (mcause), .mtval (mtval), .mip (mip)
    );

    csr_counters u_counters (
        .clk (clk), .rst (rst), .retire_inc (retire_inc),
        .cycle_count (cycle_count), .instret_count (instret_count)
    );

    csr_readout #(.hart_id(hart_id)) u_readout (
        .clk (clk), .rst (rst), .read_regs (read_regs), .csr_sel (csr_sel),
        .mstatus (mstatus), .mie (mie), .mtvec (trap_pc), .mscratch (mscratch),
        .mepc (csr_mepc), .mcause (mcause), .mtval (mtval), .mip (mip),
        .cycle_count (cycle_count), .instret_count (instret_count),
        .wb_csr (wb_csr)
    );

endmodule

// File: src/csr_readout.sv
// CSR readout: addressed value mux and writeback register
`timescale 1ns/1ps

module csr_readout #(
    parameter logic [csr_pkg::XLEN-1:0] hart_id = '0
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            read_regs,
    input  csr_pkg::csr_sel_t               csr_sel,
    input  logic [csr_pkg::XLEN-1:0]        mstatus,
    input  logic [csr_pkg::XLEN-1:0]        mie,
    input  logic [csr_pkg::XLEN-1:0]        mtvec,
    input  logic [csr_pkg::XLEN-1:0]        mscratch,
    input  logic [csr_pkg::XLEN-1:0]        mepc,
    input  logic [csr_pkg::XLEN-1:0]        mcause,
    input  logic [csr_pkg::XLEN-1:0]        mtval,
    input  logic [csr_pkg::XLEN-1:0]        mip,
    input  logic [csr_pkg::COUNTER_W-1:0]   cycle_count,
    input  logic [csr_pkg::COUNTER_W-1:0]   instret_count,
    output logic [csr_pkg::XLEN-1:0]        wb_csr
);

    logic [csr_pkg::XLEN-1:0] selected;

    always_comb begin
        case (csr_sel)
            csr_pkg::MISA:       selected = csr_pkg::MISA_VAL;
            csr_pkg::MHARTID:    selected = hart_id;
            // No vendor, architecture or implementation ID
            csr_pkg::MVENDORID,
            csr_pkg::MARCHID,
            csr_pkg::MIMPID:     selected = '0;
            csr_pkg::MSTATUS:    selected = mstatus;
            csr_pkg::MIE:        selected = mie;
            csr_pkg::MTVEC:      selected = mtvec;
            csr_pkg::MSCRATCH:   selected = mscratch;
            csr_pkg::MEPC:       selected = mepc;
            csr_pkg::MCAUSE:     selected = mcause;
            csr_pkg::MTVAL:      selected = mtval;
            csr_pkg::MIP:        selected = mip;
            csr_pkg::CYCLE_LO:   selected = cycle_count[csr_pkg::XLEN-1:0];
            csr_pkg::CYCLE_HI:   selected = cycle_count[csr_pkg::COUNTER_W-1:csr_pkg::XLEN];
            csr_pkg::INSTRET_LO: selected = instret_count[csr_pkg::XLEN-1:0];
            csr_pkg::INSTRET_HI: selected = instret_count[csr_pkg::COUNTER_W-1:csr_pkg::XLEN];
            default:             selected = '0;
        endcase
    end

    // Old value held until the next read strobe
    always_ff @(posedge clk) begin
        if (rst)
            wb_csr <= '0;
        else if (read_regs)
            wb_csr <= selected;
    end

endmodule

// File: src/csr_counters.sv
// Machine cycle and retired-instruction counters, 64 bits each
`timescale 1ns/1ps

module csr_counters (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [csr_pkg::RETIRE_W-1:0]    retire_inc,
    output logic [csr_pkg::COUNTER_W-1:0]   cycle_count,
    output logic [csr_pkg::COUNTER_W-1:0]   instret_count
);

    // Retire increment widened to counter width
    logic [csr_pkg::COUNTER_W-1:0] retire_ext;

    assign retire_ext = {{(csr_pkg::COUNTER_W-csr_pkg::RETIRE_W){1'b0}}, retire_inc};

    always_ff @(posedge clk) begin
        if (rst) begin
            cycle_count <= '0;
            instret_count <= '0;
        end else begin
            cycle_count <= cycle_count + 1'b1;
            instret_count <= instret_count + retire_ext;
        end
    end

endmodule

// File: src/csr_execute.sv
// CSR execute: read-modify-write result and machine trap registers with trap/mret updates
`timescale 1ns/1ps

module csr_execute (
    input  logic                        clk,
    input  logic                        rst,
    input  csr_pkg::csr_sel_t           csr_sel,
    input  logic                        csr_write,
    input  csr_pkg::csr_op_t            csr_op,
    input  logic [csr_pkg::XLEN-1:0]    rs1,
    input  logic [csr_pkg::XLEN-1:0]    old_value,
    input  logic                        exception_valid,
    input  logic [csr_pkg::ECODE_W-1:0] exception_code,
    input  logic [csr_pkg::XLEN-1:0]    exception_pc,
    input  logic [csr_pkg::XLEN-1:0]    exception_tval,
    input  logic                        mret,
    output logic [csr_pkg::XLEN-1:0]    mstatus,
    output logic [csr_pkg::XLEN-1:0]    mie,
    output logic [csr_pkg::XLEN-1:0]    mtvec,
    output logic [csr_pkg::XLEN-1:0]    mscratch,
    output logic [csr_pkg::XLEN-1:0]    mepc,
    output logic [csr_pkg::XLEN-1:0]    mcause,
    output logic [csr_pkg::XLEN-1:0]    mtval,
    output logic [csr_pkg::XLEN-1:0]    mip
);

    // mstatus bit positions
    localparam int MIE_BIT = 3;
    localparam int MPIE_BIT = 7;

    logic [csr_pkg::XLEN-1:0] updated;
    logic [csr_pkg::XLEN-1:0] mstatus_r;
    logic [csr_pkg::XLEN-1:0] mstatus_next;
    logic [csr_pkg::XLEN-1:0] mcause_wr;

    //////////////////////////////////////////////////////////////
    // Read-modify-write
    always_comb begin
        case (csr_op)
            csr_pkg::RW: updated = rs1;
            csr_pkg::RS: updated = old_value | rs1;
            csr_pkg::RC: updated = old_value & ~rs1;
            default:     updated = rs1;
        endcase
    end

    // Interrupt bit and exception code only
    assign mcause_wr = {updated[csr_pkg::XLEN-1],
                        {(csr_pkg::XLEN-1-csr_pkg::ECODE_W){1'b0}},
                        updated[csr_pkg::ECODE_W-1:0]};

    //////////////////////////////////////////////////////////////
    // mstatus: write, then trap entry, then mret
    always_comb begin
        mstatus_next = mstatus_r;
        if (csr_write && csr_sel == csr_pkg::MSTATUS) begin
            mstatus_next = updated & csr_pkg::MSTATUS_WR_MASK;
        end else if (exception_valid) begin
            mstatus_next[MPIE_BIT] = mstatus_r[MIE_BIT];
            mstatus_next[MIE_BIT] = 1'b0;
        end else if (mret) begin
            mstatus_next[MIE_BIT] = mstatus_r[MPIE_BIT];
            mstatus_next[MPIE_BIT] = 1'b1;
        end
    end

    // MPP is hardwired to machine mode
    assign mstatus = mstatus_r | csr_pkg::MSTATUS_MPP_VAL;

    //////////////////////////////////////////////////////////////
    // Register state
    always_ff @(posedge clk) begin
        if (rst) begin
            mstatus_r <= '0;
            mie <= '0;
            mtvec <= '0;
            mscratch <= '0;
            mepc <= '0;
            mcause <= '0;
            mtval <= '0;
            mip <= '0;
        end else begin
            mstatus_r <= mstatus_next;
            if (csr_write && csr_sel == csr_pkg::MIE)
                mie <= updated & csr_pkg::MIE_MIP_MASK;
            if (csr_write && csr_sel == csr_pkg::MIP)
                mip <= updated & csr_pkg::MIE_MIP_MASK;
            // Direct mode only, base is word aligned
            if (csr_write && csr_sel == csr_pkg::MTVEC)
                mtvec <= {updated[csr_pkg::XLEN-1:2], 2'b00};
            if (csr_write && csr_sel == csr_pkg::MSCRATCH)
                mscratch <= updated;
            // Trap entry overrides a software write
            if (exception_valid) begin
                mepc <= {exception_pc[csr_pkg::XLEN-1:2], 2'b00};
                mcause <= {{(csr_pkg::XLEN-csr_pkg::ECODE_W){1'b0}}, exception_code};
                mtval <= exception_tval;
            end else if (csr_write) begin
                if (csr_sel == csr_pkg::MEPC)
                    mepc <= {updated[csr_pkg::XLEN-1:2], 2'b00};
                if (csr_sel == csr_pkg::MCAUSE)
                    mcause <= mcause_wr;
                if (csr_sel == csr_pkg::MTVAL)
                    mtval <= updated;
            end
        end
    end

endmodule

// File: src/csr_decode.sv
// CSR address decode: register select, illegal address flag and write strobe
`timescale 1ns/1ps

module csr_decode (
    input  logic [csr_pkg::CSR_ADDR_W-1:0] csr_addr,
    input  logic                           new_request,
    input  logic                           commit,
    output csr_pkg::csr_sel_t              csr_sel,
    output logic                           csr_write,
    output logic                           illegal
);

    // Top two address bits of 11 mark a read-only CSR
    logic read_only;

    always_comb begin
        case (csr_addr)
            csr_pkg::ADDR_MISA:      csr_sel = csr_pkg::MISA;
            csr_pkg::ADDR_MVENDORID: csr_sel = csr_pkg::MVENDORID;
            csr_pkg::ADDR_MARCHID:   csr_sel = csr_pkg::MARCHID;
            csr_pkg::ADDR_MIMPID:    csr_sel = csr_pkg::MIMPID;
            csr_pkg::ADDR_MHARTID:   csr_sel = csr_pkg::MHARTID;
            csr_pkg::ADDR_MSTATUS:   csr_sel = csr_pkg::MSTATUS;
            csr_pkg::ADDR_MIE:       csr_sel = csr_pkg::MIE;
            csr_pkg::ADDR_MTVEC:     csr_sel = csr_pkg::MTVEC;
            csr_pkg::ADDR_MSCRATCH:  csr_sel = csr_pkg::MSCRATCH;
            csr_pkg::ADDR_MEPC:      csr_sel = csr_pkg::MEPC;
            csr_pkg::ADDR_MCAUSE:    csr_sel = csr_pkg::MCAUSE;
            csr_pkg::ADDR_MTVAL:     csr_sel = csr_pkg::MTVAL;
            csr_pkg::ADDR_MIP:       csr_sel = csr_pkg::MIP;
            // Machine counters and their user aliases, time follows cycle
            csr_pkg::ADDR_MCYCLE,
            csr_pkg::ADDR_CYCLE,
            csr_pkg::ADDR_TIME:      csr_sel = csr_pkg::CYCLE_LO;
            csr_pkg::ADDR_MCYCLEH,
            csr_pkg::ADDR_CYCLEH,
            csr_pkg::ADDR_TIMEH:     csr_sel = csr_pkg::CYCLE_HI;
            csr_pkg::ADDR_MINSTRET,
            csr_pkg::ADDR_INSTRET:   csr_sel = csr_pkg::INSTRET_LO;
            csr_pkg::ADDR_MINSTRETH,
            csr_pkg::ADDR_INSTRETH:  csr_sel = csr_pkg::INSTRET_HI;
            default:                 csr_sel = csr_pkg::NONE;
        endcase
    end

    assign read_only = (csr_addr[csr_pkg::CSR_ADDR_W-1 -: 2] == 2'b11);

    // Unknown address only matters while a request is active
    assign illegal = new_request && (csr_sel == csr_pkg::NONE);

    // Read-only writes are dropped quietly
    assign csr_write = commit && !read_only;

endmodule

// File: src/csr_pkg.sv
// CSR unit package: widths, CSR addresses, operation and select enums, field masks
package csr_pkg;

    //////////////////////////////////////////////////////////////
    // Widths
    localparam int XLEN = 32;
    localparam int COUNTER_W = 64;
    localparam int ECODE_W = 5;
    localparam int CSR_ADDR_W = 12;
    localparam int RETIRE_W = 2;

    //////////////////////////////////////////////////////////////
    // Operations, low bits of funct3
    typedef enum logic [1:0] {
        RW = 2'b01,
        RS = 2'b10,
        RC = 2'b11
    } csr_op_t;

    // Register named by a decoded address
    typedef enum logic [4:0] {
        MISA, MVENDORID, MARCHID, MIMPID, MHARTID,
        MSTATUS, MIE, MTVEC, MSCRATCH,
        MEPC, MCAUSE, MTVAL, MIP,
        CYCLE_LO, CYCLE_HI, INSTRET_LO, INSTRET_HI,
        NONE
    } csr_sel_t;

    //////////////////////////////////////////////////////////////
    // Machine information, read-only
    localparam logic [CSR_ADDR_W-1:0] ADDR_MVENDORID = 12'hF11;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MARCHID = 12'hF12;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MIMPID = 12'hF13;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MHARTID = 12'hF14;

    // Machine trap setup and handling
    localparam logic [CSR_ADDR_W-1:0] ADDR_MSTATUS = 12'h300;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MISA = 12'h301;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MIE = 12'h304;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MTVEC = 12'h305;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MSCRATCH = 12'h340;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MEPC = 12'h341;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MCAUSE = 12'h342;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MTVAL = 12'h343;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MIP = 12'h344;

    // Machine counters
    localparam logic [CSR_ADDR_W-1:0] ADDR_MCYCLE = 12'hB00;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MINSTRET = 12'hB02;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MCYCLEH = 12'hB80;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MINSTRETH = 12'hB82;

    // User read-only counter aliases
    localparam logic [CSR_ADDR_W-1:0] ADDR_CYCLE = 12'hC00;
    localparam logic [CSR_ADDR_W-1:0] ADDR_TIME = 12'hC01;
    localparam logic [CSR_ADDR_W-1:0] ADDR_INSTRET = 12'hC02;
    localparam logic [CSR_ADDR_W-1:0] ADDR_CYCLEH = 12'hC80;
    localparam logic [CSR_ADDR_W-1:0] ADDR_TIMEH = 12'hC81;
    localparam logic [CSR_ADDR_W-1:0] ADDR_INSTRETH = 12'hC82;

    //////////////////////////////////////////////////////////////
    // Field masks
    localparam logic [XLEN-1:0] MSTATUS_WR_MASK = 32'h0000_0088;
    localparam logic [XLEN-1:0] MSTATUS_MPP_VAL = 32'h0000_1800;
    localparam logic [XLEN-1:0] MIE_MIP_MASK = 32'h0000_0888;
    localparam logic [XLEN-1:0] MISA_VAL = 32'h4000_0100;

endpackage
